//--- Bender.yml
package:
  name: lcd_menu

sources:
  - lcd_menu_pkg.sv
  - key_decoder.sv
  - lcd_script_rom.sv
  - lcd_menu_ctrl.sv
  - cmd_fifo.sv
  - lcd_bus_driver.sv
  - lcd_menu_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - lcd_menu_props.sv
      - tb_lcd_menu.sv

//--- cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   push,
	input  lcd_menu_pkg::lcd_cmd_t push_cmd,
	input  logic                   pop,
	output lcd_menu_pkg::lcd_cmd_t head_cmd,
	output logic                   full,
	output logic                   empty
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	lcd_menu_pkg::lcd_cmd_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       count;

	// Wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign head_cmd = mem[rd_ptr];     // First-word fall-through
	assign full     = (count == CNT_W'(FIFO_DEPTH));
	assign empty    = (count == '0);

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_cmd;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Both or neither
			endcase
		end
	end

endmodule

//--- filelist.f
lcd_menu_pkg.sv
key_decoder.sv
lcd_script_rom.sv
lcd_menu_ctrl.sv
cmd_fifo.sv
lcd_bus_driver.sv
lcd_menu_top.sv
tb_clock_gen.sv
lcd_menu_props.sv
tb_lcd_menu.sv

//--- key_decoder.sv
`timescale 1ns/1ps

module key_decoder
(
	input  logic              clk,
	input  logic              reset,
	input  logic              up,       // Active low
	input  logic              left,     // Active low
	input  logic              enter,    // Active low
	input  logic              shift,
	output logic              key_event,
	output lcd_menu_pkg::key_t key
);

	lcd_menu_pkg::key_t decoded;
	logic               pressed;
	logic               held;       // Set while any key is still down

	// Shift turns up into down and left into right
	always_comb
	begin
		if (!up)
			decoded = shift ? lcd_menu_pkg::key_down : lcd_menu_pkg::key_up;
		else if (!left)
			decoded = shift ? lcd_menu_pkg::key_right : lcd_menu_pkg::key_left;
		else if (!enter)
			decoded = lcd_menu_pkg::key_enter;
		else
			decoded = lcd_menu_pkg::key_none;
	end

	assign pressed = (decoded != lcd_menu_pkg::key_none);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			held      <= 1'b0;
			key_event <= 1'b0;
			key       <= lcd_menu_pkg::key_none;
		end
		else
		begin
			key_event <= pressed && !held;  // First clock of a press only
			held      <= pressed;           // Cleared after one idle clock
			key       <= decoded;
		end
	end

endmodule

//--- lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver
#(
	parameter int TICK_DIV = 125000
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    empty,
	input  lcd_menu_pkg::lcd_cmd_t  head_cmd,
	output logic                    pop,
	output logic                    enable,
	output logic                    rs,
	output lcd_menu_pkg::lcd_byte_t data,
	output logic                    lcd_on
);

	localparam int CNT_W = $clog2(TICK_DIV + 1);

	logic [CNT_W-1:0] tick_cnt;
	logic             tick;        // One clock every TICK_DIV clocks

	assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

	// Take the head only at the start of an enable pulse
	assign pop = tick && !enable && !empty;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			enable <= 1'b0;
			rs     <= 1'b0;
			data   <= '0;
			lcd_on <= 1'b0;
		end
		else if (tick)
		begin
			lcd_on <= 1'b1;            // Powers the panel at the first tick
			if (enable)
				enable <= 1'b0;        // Falling edge latches the command
			else if (!empty)
			begin
				enable <= 1'b1;
				rs     <= head_cmd[8];
				data   <= head_cmd[7:0];
			end
		end
	end

endmodule

//--- lcd_menu_ctrl.sv
`timescale 1ns/1ps

module lcd_menu_ctrl
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   key_event,
	input  lcd_menu_pkg::key_t     key,
	input  logic                   full,
	input  logic                   empty,
	output logic                   push,
	output lcd_menu_pkg::lcd_cmd_t push_cmd
);

	lcd_menu_pkg::menu_state_t state;
	lcd_menu_pkg::script_idx_t idx;
	lcd_menu_pkg::lcd_cmd_t    rom_cmd;
	lcd_menu_pkg::digit_t      digits [lcd_menu_pkg::NUM_DIGITS];
	lcd_menu_pkg::digit_pos_t  cursor;
	logic [1:0]                step;        // 0 address, 1 character, 2 address
	lcd_menu_pkg::lcd_byte_t   cursor_addr;
	lcd_menu_pkg::lcd_byte_t   digit_char;

	// Leading digit only toggles, the rest wrap 0..9
	function automatic lcd_menu_pkg::digit_t step_digit
	(
		input lcd_menu_pkg::digit_pos_t pos,
		input lcd_menu_pkg::digit_t     d,
		input logic                     inc
	);
		if (pos == 3'd0)
			return (d == 4'd0) ? 4'd1 : 4'd0;
		if (inc)
			return (d == 4'd9) ? 4'd0 : d + 4'd1;
		return (d == 4'd0) ? 4'd9 : d - 4'd1;
	endfunction

	lcd_script_rom u_rom
	(
		.addr (idx),
		.cmd  (rom_cmd)
	);

	assign cursor_addr = lcd_menu_pkg::LINE2_ADDR | {5'd0, cursor};
	assign digit_char  = lcd_menu_pkg::ASCII_ZERO | {4'd0, digits[cursor]};

	always_comb
	begin
		push     = 1'b0;
		push_cmd = rom_cmd;
		case (state)
			lcd_menu_pkg::init_script,
			lcd_menu_pkg::screen_script,
			lcd_menu_pkg::run_script:
				push = !full;
			lcd_menu_pkg::write_digit:
			begin
				push     = !full;
				push_cmd = (step == 2'd1) ? {1'b1, digit_char} : {1'b0, cursor_addr};
			end
			default:
				push = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state  <= lcd_menu_pkg::init_script;
			idx    <= lcd_menu_pkg::INIT_FIRST;
			cursor <= '0;
			step   <= '0;
			for (int i = 0; i < lcd_menu_pkg::NUM_DIGITS - 1; i++)
				digits[i] <= 4'd0;
			digits[lcd_menu_pkg::NUM_DIGITS - 1] <= 4'd1;   // Screen starts at 1 Hz
		end
		else
		begin
			case (state)
				lcd_menu_pkg::init_script:
					if (!full)
					begin
						if (idx == lcd_menu_pkg::INIT_LAST)
						begin
							idx   <= lcd_menu_pkg::SCREEN_FIRST;
							state <= lcd_menu_pkg::screen_script;
						end
						else
							idx <= idx + 1'b1;
					end
				lcd_menu_pkg::screen_script:
					if (!full)
					begin
						if (idx == lcd_menu_pkg::SCREEN_LAST)
							state <= lcd_menu_pkg::edit;
						else
							idx <= idx + 1'b1;
					end
				lcd_menu_pkg::edit:
					if (key_event && empty)    // Keys ignored while the display catches up
					begin
						case (key)
							lcd_menu_pkg::key_up,
							lcd_menu_pkg::key_down:
							begin
								digits[cursor] <= step_digit(cursor, digits[cursor],
									key == lcd_menu_pkg::key_up);
								step  <= 2'd0;
								state <= lcd_menu_pkg::write_digit;
							end
							lcd_menu_pkg::key_left:
							begin
								cursor <= cursor - 1'b1;    // Wraps 0 to 7
								step   <= 2'd2;             // Address only
								state  <= lcd_menu_pkg::write_digit;
							end
							lcd_menu_pkg::key_right:
							begin
								cursor <= cursor + 1'b1;
								step   <= 2'd2;
								state  <= lcd_menu_pkg::write_digit;
							end
							lcd_menu_pkg::key_enter:
							begin
								idx   <= lcd_menu_pkg::RUN_FIRST;
								state <= lcd_menu_pkg::run_script;
							end
							default:
								state <= lcd_menu_pkg::edit;
						endcase
					end
				lcd_menu_pkg::write_digit:
					if (!full)
					begin
						if (step == 2'd2)
							state <= lcd_menu_pkg::edit;
						else
							step <= step + 1'b1;
					end
				lcd_menu_pkg::run_script:
					if (!full)
					begin
						if (idx == lcd_menu_pkg::RUN_LAST)
							state <= lcd_menu_pkg::hold;
						else
							idx <= idx + 1'b1;
					end
				default:
					state <= lcd_menu_pkg::hold;   // Stays until reset
			endcase
		end
	end

endmodule

//--- lcd_menu_pkg.sv
package lcd_menu_pkg;

	// Bus and command widths
	typedef logic [7:0] lcd_byte_t;
	typedef logic [8:0] lcd_cmd_t;       // {rs, byte}, rs 0 = instruction, 1 = character
	typedef logic [3:0] digit_t;
	typedef logic [2:0] digit_pos_t;     // Cursor among the eight digits
	typedef logic [5:0] script_idx_t;

	localparam int NUM_DIGITS = 8;

	// Instruction and character constants
	localparam lcd_byte_t CMD_CLEAR  = 8'h01;
	localparam lcd_byte_t LINE2_ADDR = 8'hC0;   // DDRAM address of line 2, column 0
	localparam lcd_byte_t ASCII_ZERO = 8'h30;

	// Script ROM ranges, contiguous
	localparam script_idx_t INIT_FIRST   = 6'd0;
	localparam script_idx_t INIT_LAST    = 6'd7;
	localparam script_idx_t SCREEN_FIRST = 6'd8;
	localparam script_idx_t SCREEN_LAST  = 6'd31;
	localparam script_idx_t RUN_FIRST    = 6'd32;
	localparam script_idx_t RUN_LAST     = 6'd45;

	// Decoded key events
	typedef enum logic [2:0]
	{
		key_none,
		key_up,
		key_down,
		key_left,
		key_right,
		key_enter
	} key_t;

	// Menu controller states
	typedef enum logic [2:0]
	{
		init_script,
		screen_script,
		edit,
		write_digit,
		run_script,
		hold
	} menu_state_t;

endpackage

//--- lcd_menu_props.sv
`timescale 1ns/1ps

module lcd_menu_props
#(
	parameter int TICK_DIV = 4
)
(
	input logic                    clk,
	input logic                    reset,
	input logic                    enable,
	input logic                    rs,
	input lcd_menu_pkg::lcd_byte_t data,
	input logic                    lcd_on
);

	localparam logic [8*11-1:0] LINE1    = "Frequencia:";
	localparam logic [8*11-1:0] LINE2    = "00000001 Hz";
	localparam logic [8*13-1:0] RUN_TEXT = "Executando...";

	int unsigned              err_count = 0;   // Watched by the testbench
	int unsigned              cmd_cnt;         // Commands seen before this one
	int unsigned              run_cnt;
	logic                     en_q;
	logic                     rs_q;
	lcd_menu_pkg::lcd_byte_t  data_q;
	logic                     run_seen;        // Final clear has been sent
	logic                     addr_valid;      // Last command was a digit address
	lcd_menu_pkg::digit_pos_t addr_pos;
	lcd_menu_pkg::lcd_byte_t  shadow [8];      // Characters shown on the digit row
	logic                     new_cmd;
	logic                     in_edit;

	// Power-up sequence and frequency screen, as {rs, byte}
	function automatic logic [8:0] screen_cmd(input int unsigned n);
		case (n)
			0, 1, 2, 3: return {1'b0, 8'h38};
			4:          return {1'b0, 8'h08};
			5:          return {1'b0, 8'h01};
			6:          return {1'b0, 8'h0C};
			7:          return {1'b0, 8'h06};
			19, 31:     return {1'b0, 8'hC0};
			default:
				if (n < 19)
					return {1'b1, LINE1[8*(18-n) +: 8]};
				else
					return {1'b1, LINE2[8*(30-n) +: 8]};
		endcase
	endfunction

	// Leading digit toggles, the others wrap through 0..9
	function automatic lcd_menu_pkg::lcd_byte_t stepped
	(
		input lcd_menu_pkg::digit_pos_t pos,
		input lcd_menu_pkg::lcd_byte_t  c,
		input logic                     inc
	);
		if (pos == 3'd0)
			return (c == "0") ? "1" : "0";
		if (inc)
			return (c == "9") ? "0" : c + 8'd1;
		return (c == "0") ? "9" : c - 8'd1;
	endfunction

	function automatic lcd_menu_pkg::lcd_byte_t run_char(input int unsigned k);
		if (k < 13)
			return RUN_TEXT[8*(12-k) +: 8];
		return 8'h00;
	endfunction

	assign new_cmd = enable && !en_q;                 // Rising edge of enable
	assign in_edit = (cmd_cnt >= 32) && !run_seen;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			en_q       <= 1'b0;
			rs_q       <= 1'b0;
			data_q     <= '0;
			cmd_cnt    <= 0;
			run_cnt    <= 0;
			run_seen   <= 1'b0;
			addr_valid <= 1'b0;
			addr_pos   <= '0;
			for (int i = 0; i < 8; i++)
				shadow[i] <= (i == 7) ? "1" : "0";
		end
		else
		begin
			en_q   <= enable;
			rs_q   <= rs;
			data_q <= data;
			if (new_cmd)
			begin
				cmd_cnt <= cmd_cnt + 1;
				if (in_edit && !rs)
				begin
					run_seen   <= (data == 8'h01);
					addr_valid <= (data[7:3] == 5'b11000);
					addr_pos   <= data[2:0];
				end
				else if (in_edit)
				begin
					addr_valid <= 1'b0;        // Display cursor moved on
					if (addr_valid)
						shadow[addr_pos] <= data;
				end
				else if (run_seen)
					run_cnt <= run_cnt + 1;
			end
		end
	end

	a_reset_low: assert property (@(posedge clk)
		!reset |-> !enable && !rs && !lcd_on && data == 8'h00)
	else
	begin
		err_count++;
		$error("Fail outputs in reset: enable=%h rs=%h lcd_on=%h data=%h",
			$sampled(enable), $sampled(rs), $sampled(lcd_on), $sampled(data));
	end

	a_on_stays: assert property (@(posedge clk) disable iff (!reset)
		lcd_on |=> lcd_on)
	else
	begin
		err_count++;
		$error("lcd_on fell after power-up");
	end

	a_on_with_enable: assert property (@(posedge clk) disable iff (!reset)
		enable |-> lcd_on)
	else
	begin
		err_count++;
		$error("Fail lcd_on: got %h expected 1 while enable is high", $sampled(lcd_on));
	end

	a_high_time: assert property (@(posedge clk) disable iff (!reset)
		$rose(enable) |-> enable [*TICK_DIV] ##1 !enable)
	else
	begin
		err_count++;
		$error("enable pulse did not last exactly %0d clocks", TICK_DIV);
	end

	a_low_time: assert property (@(posedge clk) disable iff (!reset)
		$fell(enable) |-> !enable [*TICK_DIV])
	else
	begin
		err_count++;
		$error("enable low gap shorter than %0d clocks", TICK_DIV);
	end

	a_stable: assert property (@(posedge clk) disable iff (!reset)
		enable && en_q |-> rs == rs_q && data == data_q)
	else
	begin
		err_count++;
		$error("Fail rs/data while enable high: got %h/%h expected %h/%h",
			$sampled(rs), $sampled(data), $sampled(rs_q), $sampled(data_q));
	end

	a_script: assert property (@(posedge clk) disable iff (!reset)
		new_cmd && cmd_cnt < 32 |-> {rs, data} == screen_cmd(cmd_cnt))
	else
	begin
		err_count++;
		$error("Fail {rs,data} at command %0d: got %h expected %h", $sampled(cmd_cnt),
			{$sampled(rs), $sampled(data)}, screen_cmd($sampled(cmd_cnt)));
	end

	a_edit_instr: assert property (@(posedge clk) disable iff (!reset)
		new_cmd && in_edit && !rs |-> (data >= 8'hC0 && data <= 8'hC7) || data == 8'h01)
	else
	begin
		err_count++;
		$error("Fail data instruction in edit: got %h expected C0..C7 or 01",
			$sampled(data));
	end

	a_digit: assert property (@(posedge clk) disable iff (!reset)
		new_cmd && in_edit && rs |-> addr_valid &&
			(data == stepped(addr_pos, shadow[addr_pos], 1'b1) ||
			 data == stepped(addr_pos, shadow[addr_pos], 1'b0)))
	else
	begin
		err_count++;
		$error("Fail data at digit %0h: got %h after %h (address valid %h)",
			$sampled(addr_pos), $sampled(data), $sampled(shadow[addr_pos]),
			$sampled(addr_valid));
	end

	a_run_text: assert property (@(posedge clk) disable iff (!reset)
		new_cmd && run_seen |-> run_cnt < 13 && rs && data == run_char(run_cnt))
	else
	begin
		err_count++;
		$error("Fail {rs,data} on run screen char %0d: got %h expected %h",
			$sampled(run_cnt), {$sampled(rs), $sampled(data)},
			{1'b1, run_char($sampled(run_cnt))});
	end

	a_run_idle: assert property (@(posedge clk) disable iff (!reset)
		run_cnt == 13 && !en_q |-> !enable)
	else
	begin
		err_count++;
		$error("Fail enable after run screen: got %h expected 0", $sampled(enable));
	end

endmodule

//--- lcd_menu_top.sv
`timescale 1ns/1ps

module lcd_menu_top
#(
	parameter int TICK_DIV   = 125000,   // 100 Hz LCD tick from the board clock
	parameter int FIFO_DEPTH = 8
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    up,
	input  logic                    left,
	input  logic                    shift,
	input  logic                    enter,
	output logic                    enable,
	output logic                    rs,
	output lcd_menu_pkg::lcd_byte_t data,
	output logic                    lcd_on
);

	logic                   key_event;
	lcd_menu_pkg::key_t     key;
	logic                   push;
	lcd_menu_pkg::lcd_cmd_t push_cmd;
	logic                   pop;
	lcd_menu_pkg::lcd_cmd_t head_cmd;
	logic                   full;
	logic                   empty;

	key_decoder u_keys
	(
		.clk       (clk),
		.reset     (reset),
		.up        (up),
		.left      (left),
		.enter     (enter),
		.shift     (shift),
		.key_event (key_event),
		.key       (key)
	);

	lcd_menu_ctrl u_ctrl
	(
		.clk       (clk),
		.reset     (reset),
		.key_event (key_event),
		.key       (key),
		.full      (full),
		.empty     (empty),
		.push      (push),
		.push_cmd  (push_cmd)
	);

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
	(
		.clk      (clk),
		.reset    (reset),
		.push     (push),
		.push_cmd (push_cmd),
		.pop      (pop),
		.head_cmd (head_cmd),
		.full     (full),
		.empty    (empty)
	);

	lcd_bus_driver #(.TICK_DIV(TICK_DIV)) u_bus
	(
		.clk      (clk),
		.reset    (reset),
		.empty    (empty),
		.head_cmd (head_cmd),
		.pop      (pop),
		.enable   (enable),
		.rs       (rs),
		.data     (data),
		.lcd_on   (lcd_on)
	);

endmodule

//--- lcd_script_rom.sv
`timescale 1ns/1ps

module lcd_script_rom
(
	input  lcd_menu_pkg::script_idx_t addr,
	output lcd_menu_pkg::lcd_cmd_t    cmd
);

	always_comb
	begin
		case (addr)
			// Power-up sequence
			6'd0, 6'd1, 6'd2, 6'd3:
				cmd = {1'b0, 8'h38};                    // Function set, 8 bit, 2 lines
			6'd4: cmd = {1'b0, 8'h08};                  // Display off
			6'd5: cmd = {1'b0, lcd_menu_pkg::CMD_CLEAR};
			6'd6: cmd = {1'b0, 8'h0C};                  // Display on, no cursor
			6'd7: cmd = {1'b0, 8'h06};                  // Entry mode, increment
			// "Frequencia:"
			6'd8:  cmd = {1'b1, 8'h46};                 // F
			6'd9:  cmd = {1'b1, 8'h72};                 // r
			6'd10: cmd = {1'b1, 8'h65};                 // e
			6'd11: cmd = {1'b1, 8'h71};                 // q
			6'd12: cmd = {1'b1, 8'h75};                 // u
			6'd13: cmd = {1'b1, 8'h65};                 // e
			6'd14: cmd = {1'b1, 8'h6E};                 // n
			6'd15: cmd = {1'b1, 8'h63};                 // c
			6'd16: cmd = {1'b1, 8'h69};                 // i
			6'd17: cmd = {1'b1, 8'h61};                 // a
			6'd18: cmd = {1'b1, 8'h3A};                 // :
			6'd19: cmd = {1'b0, lcd_menu_pkg::LINE2_ADDR};
			// "00000001 Hz"
			6'd20, 6'd21, 6'd22, 6'd23, 6'd24, 6'd25, 6'd26:
				cmd = {1'b1, lcd_menu_pkg::ASCII_ZERO};
			6'd27: cmd = {1'b1, 8'h31};                 // 1
			6'd28: cmd = {1'b1, 8'h20};                 // Space
			6'd29: cmd = {1'b1, 8'h48};                 // H
			6'd30: cmd = {1'b1, 8'h7A};                 // z
			6'd31: cmd = {1'b0, lcd_menu_pkg::LINE2_ADDR};  // Cursor back to first digit
			// Run screen, "Executando..."
			6'd32: cmd = {1'b0, lcd_menu_pkg::CMD_CLEAR};
			6'd33: cmd = {1'b1, 8'h45};                 // E
			6'd34: cmd = {1'b1, 8'h78};                 // x
			6'd35: cmd = {1'b1, 8'h65};                 // e
			6'd36: cmd = {1'b1, 8'h63};                 // c
			6'd37: cmd = {1'b1, 8'h75};                 // u
			6'd38: cmd = {1'b1, 8'h74};                 // t
			6'd39: cmd = {1'b1, 8'h61};                 // a
			6'd40: cmd = {1'b1, 8'h6E};                 // n
			6'd41: cmd = {1'b1, 8'h64};                 // d
			6'd42: cmd = {1'b1, 8'h6F};                 // o
			6'd43, 6'd44, 6'd45:
				cmd = {1'b1, 8'h2E};                    // .
			default:
				cmd = {1'b0, lcd_menu_pkg::CMD_CLEAR};
		endcase
	end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;     // 10 ns period
	end

	initial
	begin
		reset = 1'b1;
		#1 reset = 1'b0;           // Falling edge clears the flops before the first clock
		repeat (2) @(posedge clk);
		#1 reset = 1'b1;           // Released just after the second edge
	end

endmodule

//--- tb_lcd_menu.sv
`timescale 1ns/1ps

module tb_lcd_menu;

	localparam int TICK_DIV     = 4;
	localparam int SEED         = 11274;
	localparam int NUM_KEYS     = 40;
	localparam int SCREEN_CMDS  = 32;
	localparam int MAX_CMDS     = SCREEN_CMDS + 3 * NUM_KEYS + 14;
	localparam int KEY_CLKS     = (NUM_KEYS + 1) * 6 * TICK_DIV;   // Hold plus release
	localparam int IDLE_CLKS    = 8 * TICK_DIV;
	localparam int TIMEOUT_CLKS = 2 * (MAX_CMDS * 2 * TICK_DIV + KEY_CLKS + IDLE_CLKS);

	logic                    clk;
	logic                    reset;
	logic                    up;
	logic                    left;
	logic                    shift;
	logic                    enter;
	logic                    enable;
	logic                    rs;
	lcd_menu_pkg::lcd_byte_t data;
	logic                    lcd_on;
	logic                    en_prev = 1'b0;
	int unsigned             cmd_seen = 0;
	int unsigned             clear_at = 0;     // Command count including the final clear
	int unsigned             cycles = 0;

	tb_clock_gen u_clk_gen
	(
		.clk   (clk),
		.reset (reset)
	);

	lcd_menu_top #(.TICK_DIV(TICK_DIV), .FIFO_DEPTH(8)) i_dut
	(
		.clk    (clk),
		.reset  (reset),
		.up     (up),
		.left   (left),
		.shift  (shift),
		.enter  (enter),
		.enable (enable),
		.rs     (rs),
		.data   (data),
		.lcd_on (lcd_on)
	);

	bind lcd_menu_top lcd_menu_props #(.TICK_DIV(TICK_DIV)) u_props
	(
		.clk    (clk),
		.reset  (reset),
		.enable (enable),
		.rs     (rs),
		.data   (data),
		.lcd_on (lcd_on)
	);

	// Counts bus commands so the stimulus knows where the display is
	always @(posedge clk)
	begin
		cycles  <= cycles + 1;
		en_prev <= enable;
		if (enable && !en_prev)
		begin
			cmd_seen <= cmd_seen + 1;
			if (cmd_seen >= SCREEN_CMDS && !rs && data == 8'h01 && clear_at == 0)
				clear_at <= cmd_seen + 1;
		end
	end

	task automatic hold_buttons(input logic up_n, input logic left_n, input logic enter_n,
		input logic sh);
		@(posedge clk);
		#1;
		shift = sh;
		up    = up_n;
		left  = left_n;
		enter = enter_n;
		repeat (3 * TICK_DIV) @(posedge clk);
		#1;
		up    = 1'b1;
		left  = 1'b1;
		enter = 1'b1;
		repeat (3 * TICK_DIV) @(posedge clk);
	endtask

	// 0 up, 1 down, 2 left, 3 right
	task automatic press_direction(input int unsigned dir);
		case (dir)
			0:       hold_buttons(1'b0, 1'b1, 1'b1, 1'b0);
			1:       hold_buttons(1'b0, 1'b1, 1'b1, 1'b1);
			2:       hold_buttons(1'b1, 1'b0, 1'b1, 1'b0);
			default: hold_buttons(1'b1, 1'b0, 1'b1, 1'b1);
		endcase
	endtask

	initial
	begin
		int unsigned dir;
		up    = 1'b1;
		left  = 1'b1;
		shift = 1'b0;
		enter = 1'b1;
		void'($urandom(SEED));
		wait (reset === 1'b1);
		while (cmd_seen < SCREEN_CMDS)      // Frequency screen fully drawn
			@(posedge clk);
		for (int i = 0; i < NUM_KEYS; i++)
		begin
			dir = $urandom_range(3, 0);
			press_direction(dir);
		end
		hold_buttons(1'b1, 1'b1, 1'b0, 1'b0);
		while (clear_at == 0 || cmd_seen < clear_at + 13)
			@(posedge clk);
		repeat (IDLE_CLKS) @(posedge clk);  // Bus must stay quiet in hold
		if (i_dut.u_props.err_count == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("Test failures found");
			$fatal(1, "Assertion failures were reported");
		end
	end

	initial
	begin
		wait (i_dut.u_props.err_count != 0);
		$display("Test failures found");
		$fatal(1, "Stopped at the first assertion failure");
	end

	initial
	begin
		wait (cycles >= TIMEOUT_CLKS);
		$display("Run timed out after %0d clock cycles", cycles);
		$display("Test failures found");
		$fatal(1, "Timeout");
	end

endmodule
